/* uart_frame.f */
common/uart_frame_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
framer/frame_sender.sv
framer/frame_receiver.sv
logic/uart_frame_top.sv
verification/uart_frame_sva.sv
verification/tb_clock.sv
verification/tb_uart_frame.sv

/* run_sim.sh */
#!/bin/bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing -Wno-fatal --top-module tb_uart_frame \
	-f uart_frame.f -o sim_uart_frame || { echo "Build failed"; exit 1; }
./obj_dir/sim_uart_frame +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Test OK" sim.log && { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation ended without a result"; exit 1; }

/* verification/tb_uart_frame.sv */
// Testbench top for the UART string link.
// Serial loopback of random and fixed payloads, a serial injector for
// raw byte streams, frame checks at each rx_done and a cycle timeout.

`timescale 1ns/1ps

module tb_uart_frame;

	import uart_frame_pkg::*;

	localparam int byte_cycles    = 11 * clks_per_bit;  // Start, eight data and two stop bits.
	localparam int frame_count    = 9;                  // Frames sent over all tests.
	localparam int timeout_cycles = 2 * frame_count * (max_len + 4) * byte_cycles;

	logic       sys_clk;
	logic       sys_rst_n;
	frame_buf_t tx_frame;
	logic       tx_req;
	logic       tx_busy;
	logic       tx_done;
	frame_buf_t rx_frame;
	logic       rx_busy;
	logic       rx_done;
	logic       rx_overflow;
	logic       uart_rx_port;
	logic       uart_tx_port;
	logic       loopback;   // High routes the DUT output back to its input.
	logic       inj_line;   // Serial line driven by the injector.
	frame_buf_t exp_frame;  // What the next rx_done has to carry.
	logic       exp_ovf;
	int         done_cnt;
	int         cycle_cnt = 0;
	int         seed;
	string      test_name;

	assign uart_rx_port = loopback ? uart_tx_port : inj_line;

	tb_clock i_clock (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n)
	);

	uart_frame_top i_dut (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.tx_frame     (tx_frame),
		.tx_req       (tx_req),
		.tx_busy      (tx_busy),
		.tx_done      (tx_done),
		.rx_frame     (rx_frame),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done),
		.rx_overflow  (rx_overflow),
		.uart_rx_port (uart_rx_port),
		.uart_tx_port (uart_tx_port)
	);

	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1, "Simulation stopped at the first error.");
	endtask

	task automatic value_error(input string what, input int expected, input int actual);
		$display("** Error %s: %s expected 0x%0h, actual 0x%0h", test_name, what, expected, actual);
		abort_run();
	endtask

	task automatic next_cycle();
		@(posedge sys_clk);
		#2;
	endtask

	function automatic logic [7:0] pick_byte(input logic [7:0] prev, input logic last);
		logic [7:0] value;
		value = 8'($random(seed));
		if (value == frame_mark && (prev == frame_mark || last))
			value = value + 8'd1;  // No "&&" and no trailing marker.
		return value;
	endfunction

	task automatic make_random(input int len, output frame_buf_t frame);
		logic [7:0] prev;
		prev  = 8'h00;
		frame = '0;
		frame.length = len_w'(len);
		for (int i = 0; i < len; i++) begin
			frame.data[i] = pick_byte(prev, i == len - 1);
			prev          = frame.data[i];
		end
	endtask

	task automatic make_text(input string text, output frame_buf_t frame);
		frame = '0;
		frame.length = len_w'(text.len());
		for (int i = 0; i < text.len(); i++)
			frame.data[i] = text[i];
	endtask

	task automatic request_frame(input frame_buf_t frame);
		tx_frame = frame;
		tx_req   = 1'b1;
		next_cycle();
		tx_req   = 1'b0;
	endtask

	task automatic wait_tx_done();
		while (!tx_done)
			next_cycle();
	endtask

	task automatic wait_rx_done(input int target);
		while (done_cnt < target)
			next_cycle();
	endtask

	task automatic loop_frame(input string name, input frame_buf_t frame);
		int start_cnt;
		test_name = name;
		start_cnt = done_cnt;
		exp_frame = frame;
		exp_ovf   = 1'b0;
		request_frame(frame);
		wait_tx_done();
		wait_rx_done(start_cnt + 1);
	endtask

	// Start bit, eight data bits LSB first and two stop bits.
	task automatic inject_byte(input logic [7:0] value);
		logic [10:0] bits;
		bits = {2'b11, value, 1'b0};
		for (int i = 0; i < 11; i++) begin
			inj_line = bits[i];
			repeat (clks_per_bit) next_cycle();
		end
	endtask

	task automatic inject_double_mark();
		inject_byte(frame_mark);
		inject_byte(frame_mark);
	endtask

	// Every finished frame is compared with the expected one.
	always @(negedge sys_clk) begin
		if (sys_rst_n && rx_done) begin
			done_cnt++;
			assert (rx_frame.length == exp_frame.length)
				else value_error("length", exp_frame.length, rx_frame.length);
			for (int i = 0; i < max_len; i++)
				if (i < int'(exp_frame.length))
					assert (rx_frame.data[i] == exp_frame.data[i])
						else value_error($sformatf("data[%0d]", i), exp_frame.data[i],
							rx_frame.data[i]);
			assert (rx_overflow == exp_ovf)
				else value_error("rx_overflow", exp_ovf, rx_overflow);
		end
	end

	always @(negedge sys_clk) begin
		if (i_dut.i_uart_frame_sva.error_cnt != 0) begin
			$display("A protocol assertion on the DUT failed.");
			abort_run();
		end
	end

	always @(posedge sys_clk) begin
		cycle_cnt++;
		if (cycle_cnt > timeout_cycles) begin
			$display("Timeout: the tests did not finish within %0d cycles.", timeout_cycles);
			abort_run();
		end
	end

	initial begin
		frame_buf_t frame;
		int         start_cnt;
		logic [7:0] prev;
		logic [7:0] value;
		seed      = 41105;
		tx_frame  = '0;
		tx_req    = 1'b0;
		loopback  = 1'b1;
		inj_line  = 1'b1;  // Idle line level.
		exp_frame = '0;
		exp_ovf   = 1'b0;
		done_cnt  = 0;
		test_name = "reset";
		wait (sys_rst_n);
		next_cycle();

		make_random(1, frame);
		loop_frame("loopback length 1", frame);
		make_random(7, frame);
		loop_frame("loopback length 7", frame);
		make_random(max_len, frame);
		loop_frame("loopback length max_len", frame);

		frame = '0;
		loop_frame("empty payload", frame);

		make_text("ab&cd", frame);
		loop_frame("single marker in payload", frame);

		// A second request in the middle of a frame must be dropped.
		test_name = "request while busy";
		make_random(7, frame);
		exp_frame = frame;
		start_cnt = done_cnt;
		request_frame(frame);
		repeat (byte_cycles) next_cycle();
		make_text("zz", frame);
		request_frame(frame);
		wait_tx_done();
		wait_rx_done(start_cnt + 1);
		repeat (8 * byte_cycles) next_cycle();
		assert (!tx_busy)
			else begin
				$display("tx_busy rose again after the frame, so the busy request was taken.");
				abort_run();
			end
		assert (done_cnt == start_cnt + 1)
			else value_error("rx_done count", start_cnt + 1, done_cnt);

		test_name = "overflow";
		loopback  = 1'b0;
		exp_frame = '0;
		exp_frame.length = len_w'(max_len);
		exp_ovf   = 1'b1;
		start_cnt = done_cnt;
		prev      = 8'h00;
		inject_double_mark();
		for (int i = 0; i < max_len + 3; i++) begin
			value = pick_byte(prev, i == max_len + 2);
			if (i < max_len)
				exp_frame.data[i] = value;
			inject_byte(value);
			prev = value;
		end
		inject_double_mark();
		wait_rx_done(start_cnt + 1);

		// A lone marker before a good frame gives no frame of its own.
		test_name = "lone marker";
		make_text("ok", frame);
		exp_frame = frame;
		exp_ovf   = 1'b0;
		start_cnt = done_cnt;
		inject_byte(frame_mark);
		assert (rx_busy)
			else begin
				$display("rx_busy stayed low after the first marker of a frame.");
				abort_run();
			end
		inject_byte("x");
		assert (!rx_busy)
			else begin
				$display("rx_busy stayed high after a lone marker and a data byte.");
				abort_run();
			end
		inject_double_mark();
		for (int i = 0; i < 2; i++)
			inject_byte(frame.data[i]);
		inject_double_mark();
		wait_rx_done(start_cnt + 1);

		next_cycle();
		if (i_dut.i_uart_frame_sva.error_cnt == 0) begin
			$display("Test OK");
			$finish;
		end else begin
			$display("A protocol assertion on the DUT failed.");
			abort_run();
		end
	end

endmodule

/* verification/tb_clock.sv */
// Clock and reset source for the testbench.
// 40 ns sys_clk, sys_rst_n held low for the first three rising edges.

`timescale 1ns/1ps

module tb_clock (
	output logic sys_clk,
	output logic sys_rst_n
);

	localparam int half_period = 20;  // Half of the 40 ns period.
	localparam int rst_cycles  = 3;

	initial begin
		sys_clk = 1'b0;
		forever #half_period sys_clk = ~sys_clk;
	end

	initial begin
		sys_rst_n = 1'b0;
		repeat (rst_cycles) @(posedge sys_clk);
		#2 sys_rst_n = 1'b1;  // Released with the other inputs, just after the edge.
	end

endmodule

/* verification/uart_frame_sva.sv */
// Protocol checker for the UART string link, bound to the top level.
// Covers the done pulses, tx_busy timing, the idle serial line
// and the timing of byte requests to the byte transmitter.

`timescale 1ns/1ps

module uart_frame_sva (
	input logic                       sys_clk,
	input logic                       sys_rst_n,
	input logic                       tx_busy,
	input logic                       tx_done,
	input logic                       rx_done,
	input logic                       uart_tx_port,
	input logic                       byte_req,
	input uart_frame_pkg::bit_state_e tx_state
);

	import uart_frame_pkg::*;

	int error_cnt = 0;  // Failures so far, watched by the testbench.

	tx_done_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |=> !tx_done)
		else begin
			$error("tx_done lasted more than one cycle.");
			error_cnt++;
		end

	rx_done_pulse: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_done |=> !rx_done)
		else begin
			$error("rx_done lasted more than one cycle.");
			error_cnt++;
		end

	// The end of a frame is the only way out of busy.
	busy_fall: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(tx_done || $fell(tx_busy)) |-> (tx_done && $fell(tx_busy)))
		else begin
			$error("tx_busy and tx_done did not change on the same edge.");
			error_cnt++;
		end

	line_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!tx_busy |-> uart_tx_port)
		else begin
			$error("uart_tx_port was low while tx_busy was low.");
			error_cnt++;
		end

	req_in_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		byte_req |-> (tx_state == bit_idle))
		else begin
			$error("byte_req came while uart_tx was not idle.");
			error_cnt++;
		end

endmodule

bind uart_frame_top uart_frame_sva i_uart_frame_sva (
	.sys_clk      (sys_clk),
	.sys_rst_n    (sys_rst_n),
	.tx_busy      (tx_busy),
	.tx_done      (tx_done),
	.rx_done      (rx_done),
	.uart_tx_port (uart_tx_port),
	.byte_req     (byte_req),
	.tx_state     (i_uart_tx.state)
);

/* logic/uart_frame_top.sv */
// Top level of the UART string link.
// Frame sender feeds the byte transmitter, the byte receiver feeds the
// frame receiver. Host string ports and the two serial pins go outside.

`timescale 1ns/1ps

module uart_frame_top (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  uart_frame_pkg::frame_buf_t tx_frame,
	input  logic                       tx_req,
	output logic                       tx_busy,
	output logic                       tx_done,
	output uart_frame_pkg::frame_buf_t rx_frame,
	output logic                       rx_busy,
	output logic                       rx_done,
	output logic                       rx_overflow,
	input  logic                       uart_rx_port,
	output logic                       uart_tx_port
);

	logic [7:0] byte_data;    // Sender to transmitter.
	logic       byte_req;
	logic       byte_done;
	logic [7:0] rx_byte;      // Receiver to frame receiver.
	logic       rx_byte_vld;

	frame_sender i_frame_sender (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_frame  (tx_frame),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.byte_data (byte_data),
		.byte_req  (byte_req),
		.byte_done (byte_done)
	);

	uart_tx i_uart_tx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.byte_data    (byte_data),
		.byte_req     (byte_req),
		.byte_done    (byte_done),
		.uart_tx_port (uart_tx_port)
	);

	uart_rx i_uart_rx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.uart_rx_port (uart_rx_port),
		.rx_byte      (rx_byte),
		.rx_byte_vld  (rx_byte_vld)
	);

	frame_receiver i_frame_receiver (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.rx_byte     (rx_byte),
		.rx_byte_vld (rx_byte_vld),
		.rx_frame    (rx_frame),
		.rx_busy     (rx_busy),
		.rx_done     (rx_done),
		.rx_overflow (rx_overflow)
	);

endmodule

/* framer/frame_receiver.sv */
// Frame receiver for the string link.
// Hunts for two markers in a row, stores the payload at the running length
// and reports the string on a done pulse when two markers end the frame.
// A single marker inside the payload is kept as data.

`timescale 1ns/1ps

module frame_receiver (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  logic [7:0]                 rx_byte,
	input  logic                       rx_byte_vld,
	output uart_frame_pkg::frame_buf_t rx_frame,
	output logic                       rx_busy,
	output logic                       rx_done,
	output logic                       rx_overflow
);

	import uart_frame_pkg::*;

	recv_state_e             state;
	logic [max_len-1:0][7:0] rx_data;
	logic [len_w-1:0]        rx_len;   // Length reported with the last finished frame.
	logic [len_w-1:0]        fill;     // Running length of the frame being collected.
	logic                    dropped;  // Set once a byte did not fit.
	logic                    is_mark;
	logic                    is_data;
	logic                    store_one;
	logic                    store_pair;
	logic                    room1;
	logic                    room2;

	assign is_mark    = rx_byte_vld && (rx_byte == frame_mark);
	assign is_data    = rx_byte_vld && (rx_byte != frame_mark);
	assign store_one  = (state == recv_body) && is_data;
	assign store_pair = (state == recv_mark3) && is_data;  // Held marker plus this byte.
	assign room1      = (fill < len_w'(max_len));
	assign room2      = (fill < len_w'(max_len - 1));

	assign rx_busy  = (state != recv_idle);
	assign rx_done  = (state == recv_finish);
	assign rx_frame = '{length: rx_len, data: rx_data};

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state       <= recv_idle;
			rx_len      <= '0;
			fill        <= '0;
			dropped     <= 1'b0;
			rx_overflow <= 1'b0;
		end else begin
			case (state)
				recv_idle: begin
					if (is_mark) begin
						state       <= recv_mark1;
						rx_overflow <= 1'b0;
					end
				end
				recv_mark1: begin
					if (is_mark) begin
						state   <= recv_body;
						fill    <= '0;
						dropped <= 1'b0;
					end else if (rx_byte_vld) begin
						state <= recv_idle;  // A lone marker is not a frame start.
					end
				end
				recv_body: begin
					if (is_mark) begin
						state <= recv_mark3;
					end else if (store_one) begin
						if (room1)
							fill <= fill + 1'b1;
						else
							dropped <= 1'b1;
					end
				end
				recv_mark3: begin
					if (is_mark) begin
						state       <= recv_finish;
						rx_len      <= fill;
						rx_overflow <= dropped;
					end else if (store_pair) begin
						state <= recv_body;
						if (room2) begin
							fill <= fill + len_w'(2);
						end else if (room1) begin
							fill    <= fill + 1'b1;
							dropped <= 1'b1;
						end else begin
							dropped <= 1'b1;
						end
					end
				end
				recv_finish: state <= recv_idle;
				default:     state <= recv_idle;
			endcase
		end
	end

	// Payload bytes land at the running length while there is room.
	always_ff @(posedge sys_clk) begin
		if (store_one && room1)
			rx_data[fill] <= rx_byte;
		if (store_pair && room1)
			rx_data[fill] <= frame_mark;
		if (store_pair && room2)
			rx_data[fill + 1'b1] <= rx_byte;
	end

endmodule

/* framer/frame_sender.sv */
// Frame sender for the string link.
// Accepts a buffered string on the request/busy/done handshake and sends
// it as two markers, the payload bytes and two more markers through uart_tx.

`timescale 1ns/1ps

module frame_sender (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  uart_frame_pkg::frame_buf_t tx_frame,
	input  logic                       tx_req,
	output logic                       tx_busy,
	output logic                       tx_done,
	output logic [7:0]                 byte_data,
	output logic                       byte_req,
	input  logic                       byte_done
);

	import uart_frame_pkg::*;

	send_state_e      state;
	send_state_e      state_nxt;
	frame_buf_t       frame_buf;  // Copy of the host string taken on acceptance.
	logic [len_w-1:0] byte_cnt;   // Index of the next payload byte.
	logic             accept;
	logic             send_nxt;
	logic [7:0]       byte_nxt;

	// Busy drops in finish so that it falls on the same edge tx_done rises.
	assign tx_busy = (state != send_idle) && (state != send_finish);
	assign tx_done = (state == send_finish);
	assign accept  = tx_req && !tx_busy;

	always_comb begin
		state_nxt = state;
		send_nxt  = 1'b0;
		byte_nxt  = frame_mark;
		if (accept) begin
			state_nxt = send_mark1;
			send_nxt  = 1'b1;
		end else begin
			case (state)
				send_idle: state_nxt = send_idle;
				send_mark1: begin
					if (byte_done) begin
						state_nxt = send_mark2;
						send_nxt  = 1'b1;
					end
				end
				send_mark2: begin
					if (byte_done) begin
						send_nxt = 1'b1;
						if (frame_buf.length == '0) begin
							state_nxt = send_mark3;  // Empty payload goes straight to the end markers.
						end else begin
							state_nxt = send_body;
							byte_nxt  = frame_buf.data[0];
						end
					end
				end
				send_body: begin
					if (byte_done) begin
						send_nxt = 1'b1;
						if (byte_cnt == frame_buf.length)
							state_nxt = send_mark3;
						else
							byte_nxt = frame_buf.data[byte_cnt];
					end
				end
				send_mark3: begin
					if (byte_done) begin
						state_nxt = send_mark4;
						send_nxt  = 1'b1;
					end
				end
				send_mark4: begin
					if (byte_done)
						state_nxt = send_finish;
				end
				send_finish: state_nxt = send_idle;
				default:     state_nxt = send_idle;
			endcase
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= send_idle;
			byte_req <= 1'b0;
			byte_cnt <= '0;
		end else begin
			state    <= state_nxt;
			byte_req <= send_nxt;  // One-cycle request on the cycle after byte_done.
			if (state == send_mark2 && byte_done)
				byte_cnt <= len_w'(1);
			else if (state == send_body && byte_done)
				byte_cnt <= byte_cnt + 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept)
			frame_buf <= tx_frame;
		if (send_nxt)
			byte_data <= byte_nxt;
	end

endmodule

/* uart/uart_rx.sv */
// Byte receiver for an 8N serial line with a fixed bit time.
// Two-flop synchronizer, falling edge detect, start bit recheck at mid bit,
// mid-bit sampling of the data bits and a stop bit check.
// rx_byte_vld pulses in the middle of a valid stop bit.

`timescale 1ns/1ps

module uart_rx (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic       uart_rx_port,
	output logic [7:0] rx_byte,
	output logic       rx_byte_vld
);

	import uart_frame_pkg::*;

	bit_state_e       state;
	logic             rx_meta;   // First synchronizer stage.
	logic             rx_sync;   // Second synchronizer stage.
	logic             rx_prev;   // Delayed copy for edge detection.
	logic             rx_fall;
	logic [cnt_w-1:0] clk_cnt;
	logic [2:0]       bit_cnt;
	logic [7:0]       rx_shift;  // Bits arrive LSB first and enter at the top.
	logic             bit_mid;
	logic             start_mid;

	assign rx_fall   = rx_prev && !rx_sync;
	assign bit_mid   = (clk_cnt == cnt_w'(clks_per_bit - 1));  // One bit time after the last sample.
	assign start_mid = (clk_cnt == cnt_w'(mid_bit));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= uart_rx_port;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state       <= bit_idle;
			clk_cnt     <= '0;
			bit_cnt     <= '0;
			rx_byte_vld <= 1'b0;
		end else begin
			rx_byte_vld <= 1'b0;
			clk_cnt     <= clk_cnt + 1'b1;
			case (state)
				bit_idle: begin
					clk_cnt <= '0;
					if (rx_fall)
						state <= bit_start;
				end
				bit_start: begin
					if (start_mid) begin
						clk_cnt <= '0;
						bit_cnt <= '0;
						state   <= rx_sync ? bit_idle : bit_data;  // A glitch is not a start bit.
					end
				end
				bit_data: begin
					if (bit_mid) begin
						clk_cnt <= '0;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= bit_stop;
					end
				end
				bit_stop: begin
					if (bit_mid) begin
						rx_byte_vld <= rx_sync;  // Framing error drops the byte.
						state       <= bit_idle;
					end
				end
				default: state <= bit_idle;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == bit_data && bit_mid)
			rx_shift <= {rx_sync, rx_shift[7:1]};
		if (state == bit_stop && bit_mid && rx_sync)
			rx_byte <= rx_shift;  // Held until the next good byte.
	end

endmodule

/* uart/uart_tx.sv */
// Byte transmitter for an 8N serial line with a fixed bit time.
// One start bit, eight data bits LSB first, then tx_stop_bits stop bits.
// byte_done marks the last cycle of the last stop bit.

`timescale 1ns/1ps

module uart_tx (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  logic [7:0] byte_data,
	input  logic       byte_req,
	output logic       byte_done,
	output logic       uart_tx_port
);

	import uart_frame_pkg::*;

	bit_state_e       state;
	logic [cnt_w-1:0] clk_cnt;   // Cycles spent in the current bit.
	logic [2:0]       bit_cnt;   // Data bit or stop bit index.
	logic [7:0]       tx_shift;  // Next data bit sits in bit 0.
	logic             bit_end;

	assign bit_end   = (clk_cnt == cnt_w'(clks_per_bit - 1));
	assign byte_done = (state == bit_stop) && bit_end && (bit_cnt == 3'(tx_stop_bits - 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state        <= bit_idle;
			clk_cnt      <= '0;
			bit_cnt      <= '0;
			uart_tx_port <= 1'b1;  // Line idles high.
		end else begin
			clk_cnt <= (state == bit_idle || bit_end) ? '0 : clk_cnt + 1'b1;
			case (state)
				bit_idle: begin
					uart_tx_port <= 1'b1;
					if (byte_req) begin
						state        <= bit_start;
						uart_tx_port <= 1'b0;  // Start bit begins on the accepting edge.
					end
				end
				bit_start: begin
					if (bit_end) begin
						state        <= bit_data;
						bit_cnt      <= '0;
						uart_tx_port <= tx_shift[0];
					end
				end
				bit_data: begin
					if (bit_end) begin
						if (bit_cnt == 3'd7) begin
							state        <= bit_stop;
							bit_cnt      <= '0;
							uart_tx_port <= 1'b1;
						end else begin
							bit_cnt      <= bit_cnt + 1'b1;
							uart_tx_port <= tx_shift[0];
						end
					end
				end
				bit_stop: begin
					if (bit_end) begin
						if (bit_cnt == 3'(tx_stop_bits - 1))
							state <= bit_idle;
						else
							bit_cnt <= bit_cnt + 1'b1;
					end
				end
				default: state <= bit_idle;
			endcase
		end
	end

	// The byte is latched on the request and shifted once per data bit.
	always_ff @(posedge sys_clk) begin
		if (state == bit_idle && byte_req)
			tx_shift <= byte_data;
		else if (bit_end && (state == bit_start || state == bit_data))
			tx_shift <= tx_shift >> 1;
	end

endmodule

/* common/uart_frame_pkg.sv */
// Shared definitions for the UART string link.
// Holds the bit timing, buffer sizes, the frame marker byte,
// the state enums of all four state machines and the frame buffer struct.

package uart_frame_pkg;

	// Serial timing.
	localparam int clks_per_bit = 8;                         // System clocks per serial bit.
	localparam int tx_stop_bits = 2;                         // Stop bits sent after each byte.
	localparam int cnt_w        = $clog2(clks_per_bit + 1);  // Width of the bit-time counter.
	localparam int mid_bit      = (clks_per_bit - 1) / 2;    // Offset of the start bit centre.

	// Frame buffer sizes.
	localparam int max_len = 32;  // Payload bytes the buffer can hold.
	localparam int len_w   = 6;   // Wide enough to hold max_len itself.

	localparam logic [7:0] frame_mark = 8'h26;  // ASCII "&" used as the frame marker.

	// A payload string together with its length.
	// Byte 0 sits in the lowest bits of data.
	typedef struct packed {
		logic [len_w-1:0]          length;
		logic [max_len-1:0][7:0]   data;
	} frame_buf_t;

	// Bit-level state of the byte transmitter and the byte receiver.
	typedef enum logic [1:0] {
		bit_idle,
		bit_start,
		bit_data,
		bit_stop
	} bit_state_e;

	// Frame sender states, one per marker plus the payload.
	typedef enum logic [2:0] {
		send_idle,
		send_mark1,
		send_mark2,
		send_body,
		send_mark3,
		send_mark4,
		send_finish
	} send_state_e;

	// Frame receiver states.
	// mark3 holds a marker seen inside the payload until the next byte decides.
	typedef enum logic [2:0] {
		recv_idle,
		recv_mark1,
		recv_body,
		recv_mark3,
		recv_finish
	} recv_state_e;

endpackage
